//--- lwc_cfg.svh
// LWC I/O controller configuration
`ifndef LWC_CFG_SVH
`define LWC_CFG_SVH

// PDI and DO word width
`define LWC_W 32

// Instruction opcodes, top nibble of the instruction word
`define LWC_OP_ENC 4'b0010
`define LWC_OP_HASH 4'b1000

// Segment type codes, top nibble of a segment header
`define LWC_SEG_NPUB 4'b1101
`define LWC_SEG_AD 4'b0001
`define LWC_SEG_MSG 4'b0100
`define LWC_SEG_CT 4'b0101

// Segment header fields
`define LWC_HDR_EOT 25
`define LWC_HDR_LAST 24
`define LWC_HDR_LEN_W 16

// Closing status word, success code in the top nibble
`define LWC_STATUS_OK 32'hE000_0000

`define LWC_FIFO_DEPTH 4

`endif

//--- lwc_pkg.sv
// Shared types for the LWC I/O path
`include "lwc_cfg.svh"

package lwc_pkg;

    // What a queued entry turns into on DO
    typedef enum logic [1:0] {
        kind_header = 2'd0,
        kind_data   = 2'd1,
        kind_status = 2'd2
    } entry_kind_t;

    // One queued output word
    // nbytes counts valid bytes from the MSB down, only meaningful for data
    typedef struct packed {
        entry_kind_t       kind;
        logic [`LWC_W-1:0] word;
        logic [2:0]        nbytes;
        logic              eot;
    } fifo_entry_t;

endpackage

//--- lwc_segment_parser.sv
// PDI instruction and segment parser
`timescale 1ns/1ps
`include "lwc_cfg.svh"

module lwc_segment_parser (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`LWC_W-1:0]    pdi_data,
    input  logic                 pdi_valid,
    output logic                 pdi_ready,
    output logic                 push,
    output lwc_pkg::fifo_entry_t push_entry,
    input  logic                 full
);
    import lwc_pkg::*;

    typedef enum logic [2:0] {
        s_reset,
        s_inst,
        s_decode,
        s_hdr,
        s_data,
        s_status
    } state_t;

    // Segment type currently being walked
    localparam logic [1:0] ph_npub = 2'd0;
    localparam logic [1:0] ph_ad   = 2'd1;
    localparam logic [1:0] ph_msg  = 2'd2;
    localparam logic [1:0] ph_hash = 2'd3;

    localparam logic [`LWC_HDR_LEN_W-1:0] bytes_per_word = 4;

    state_t                    state_q;
    state_t                    state_d;
    logic [1:0]                phase_q;
    logic [1:0]                phase_d;
    logic [3:0]                inst_q;
    logic [`LWC_HDR_LEN_W-1:0] rem_q;
    logic [`LWC_HDR_LEN_W-1:0] rem_d;
    logic                      eot_q;
    logic                      eot_d;
    logic                      last_q;
    logic                      last_d;
    logic                      accept;
    logic [`LWC_HDR_LEN_W-1:0] hdr_len;
    logic [2:0]                word_bytes;
    logic                      seg_done;
    logic                      seg_eot;
    logic                      seg_last;
    logic [3:0]                exp_type;

    assign pdi_ready = (state_q inside {s_inst, s_hdr, s_data}) && !full;
    assign accept    = pdi_valid && pdi_ready;
    assign hdr_len   = pdi_data[`LWC_HDR_LEN_W-1:0];

    // Bytes carried by the current data word
    assign word_bytes = (rem_q > bytes_per_word) ? 3'd4 : rem_q[2:0];

    // Only message headers and message data go downstream
    assign push = (accept && phase_q == ph_msg && (state_q inside {s_hdr, s_data}))
                  || (state_q == s_status && !full);

    always_comb begin
        push_entry      = '0;
        push_entry.word = pdi_data;
        if (state_q == s_status) begin
            push_entry.kind = kind_status;
            push_entry.word = '0;
            push_entry.eot  = 1'b1;
        end else if (state_q == s_data) begin
            push_entry.kind   = kind_data;
            push_entry.nbytes = word_bytes;
            push_entry.eot    = eot_q;
        end else begin
            push_entry.kind = kind_header;
            push_entry.eot  = pdi_data[`LWC_HDR_EOT];
        end
    end

    always_comb begin
        state_d  = state_q;
        phase_d  = phase_q;
        rem_d    = rem_q;
        eot_d    = eot_q;
        last_d   = last_q;
        seg_done = 1'b0;
        seg_eot  = eot_q;
        seg_last = last_q;
        case (state_q)
            s_reset: state_d = s_inst;
            s_inst: begin
                if (accept) begin
                    state_d = s_decode;
                end
            end
            s_decode: begin
                // Unknown opcodes are dropped here
                case (inst_q)
                    `LWC_OP_ENC: begin
                        phase_d = ph_npub;
                        state_d = s_hdr;
                    end
                    `LWC_OP_HASH: begin
                        phase_d = ph_hash;
                        state_d = s_hdr;
                    end
                    default: state_d = s_inst;
                endcase
            end
            s_hdr: begin
                if (accept) begin
                    rem_d  = hdr_len;
                    eot_d  = pdi_data[`LWC_HDR_EOT];
                    last_d = pdi_data[`LWC_HDR_LAST];
                    if (hdr_len == '0) begin
                        // Empty segment carries no data words
                        seg_done = 1'b1;
                        seg_eot  = pdi_data[`LWC_HDR_EOT];
                        seg_last = pdi_data[`LWC_HDR_LAST];
                    end else begin
                        state_d = s_data;
                    end
                end
            end
            s_data: begin
                if (accept) begin
                    rem_d = rem_q - {{(`LWC_HDR_LEN_W-3){1'b0}}, word_bytes};
                    if (rem_q <= bytes_per_word) begin
                        seg_done = 1'b1;
                    end
                end
            end
            s_status: begin
                if (!full) begin
                    state_d = s_inst;
                end
            end
            default: state_d = s_reset;
        endcase

        // Another segment of the same type, the next type, or the status word
        if (seg_done) begin
            if (seg_last || (seg_eot && (phase_q inside {ph_msg, ph_hash}))) begin
                state_d = s_status;
            end else if (seg_eot) begin
                phase_d = phase_q + 2'd1;
                state_d = s_hdr;
            end else begin
                state_d = s_hdr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= s_reset;
            phase_q <= ph_npub;
            inst_q  <= '0;
            rem_q   <= '0;
            eot_q   <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            phase_q <= phase_d;
            rem_q   <= rem_d;
            eot_q   <= eot_d;
            last_q  <= last_d;
            if (state_q == s_inst && accept) begin
                inst_q <= pdi_data[`LWC_W-1 -: 4];
            end
        end
    end

    always_comb begin
        case (phase_q)
            ph_npub: exp_type = `LWC_SEG_NPUB;
            ph_ad:   exp_type = `LWC_SEG_AD;
            default: exp_type = `LWC_SEG_MSG;
        endcase
    end

    // Counter loaded by the header must still hold bytes in every data cycle
    a_rem_nonzero: assert property (@(posedge clk) disable iff (!rst)
        state_q == s_data |-> rem_q != '0);

    // Encryption headers follow the npub, ad, msg order
    a_hdr_order: assert property (@(posedge clk) disable iff (!rst)
        (accept && state_q == s_hdr && phase_q != ph_hash)
        |-> pdi_data[`LWC_W-1 -: 4] == exp_type);

endmodule

//--- lwc_entry_fifo.sv
// Entry FIFO between parser and DO formatter
`timescale 1ns/1ps
`include "lwc_cfg.svh"

module lwc_entry_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  lwc_pkg::fifo_entry_t push_entry,
    input  logic                 pop,
    output lwc_pkg::fifo_entry_t head,
    output logic                 full,
    output logic                 empty
);
    import lwc_pkg::*;

    localparam int depth = `LWC_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

    fifo_entry_t      mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    assign head  = mem[rd_ptr];
    assign full  = (count == full_cnt);
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst)
        pop |-> !empty);
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        push |-> !full);

endmodule

//--- lwc_do_formatter.sv
// DO word formatter
`timescale 1ns/1ps
`include "lwc_cfg.svh"

module lwc_do_formatter (
    input  lwc_pkg::fifo_entry_t head,
    input  logic                 empty,
    output logic                 pop,
    output logic [`LWC_W-1:0]    do_data,
    output logic                 do_valid,
    output logic                 do_last,
    input  logic                 do_ready
);
    import lwc_pkg::*;

    localparam int word_bytes = `LWC_W / 8;

    logic [`LWC_W-1:0] byte_mask;

    // Head of the FIFO is presented directly on DO
    assign do_valid = !empty;
    assign pop      = !empty && do_ready;
    assign do_last  = !empty && (head.kind == kind_status);

    // Byte 0 is the most significant one
    always_comb begin
        byte_mask = '0;
        for (int i = 0; i < word_bytes; i++) begin
            if (i < int'(head.nbytes)) begin
                byte_mask[`LWC_W-1-8*i -: 8] = 8'hff;
            end
        end
    end

    always_comb begin
        case (head.kind)
            kind_header: begin
                // Message header goes out as a ciphertext header
                do_data = {`LWC_SEG_CT, head.word[`LWC_W-5:0]};
            end
            kind_data: begin
                // Padding beyond the segment length is cleared
                do_data = head.word & byte_mask;
            end
            kind_status: begin
                do_data = `LWC_STATUS_OK;
            end
            default: begin
                do_data = '0;
            end
        endcase
    end

    // Data entries carry between one and four valid bytes
    always_comb begin
        if (!empty && head.kind == kind_data) begin
            a_nbytes_range: assert final (head.nbytes >= 3'd1
                                          && head.nbytes <= 3'(word_bytes));
        end
    end

endmodule

//--- lwc_io_top.sv
// LWC PDI to DO controller top
`timescale 1ns/1ps
`include "lwc_cfg.svh"

module lwc_io_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [`LWC_W-1:0] pdi_data,
    input  logic              pdi_valid,
    output logic              pdi_ready,
    output logic [`LWC_W-1:0] do_data,
    output logic              do_valid,
    output logic              do_last,
    input  logic              do_ready
);
    import lwc_pkg::*;

    logic        push;
    fifo_entry_t push_entry;
    logic        full;
    logic        pop;
    fifo_entry_t head;
    logic        empty;

    lwc_segment_parser u_parser (
        .clk        (clk),
        .rst        (rst),
        .pdi_data   (pdi_data),
        .pdi_valid  (pdi_valid),
        .pdi_ready  (pdi_ready),
        .push       (push),
        .push_entry (push_entry),
        .full       (full)
    );

    lwc_entry_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .full       (full),
        .empty      (empty)
    );

    lwc_do_formatter u_formatter (
        .head     (head),
        .empty    (empty),
        .pop      (pop),
        .do_data  (do_data),
        .do_valid (do_valid),
        .do_last  (do_last),
        .do_ready (do_ready)
    );

endmodule

//--- tb_lwc_tasks.svh
// LWC testbench driver and check tasks
`ifndef TB_LWC_TASKS_SVH
`define TB_LWC_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("ERR at %0t: %s is %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_reset_outputs();
    check_value("pdi_ready", {31'b0, pdi_ready}, 32'd0);
    check_value("do_valid", {31'b0, do_valid}, 32'd0);
    check_value("do_last", {31'b0, do_last}, 32'd0);
endtask

function automatic logic [31:0] make_header(input logic [3:0] seg_type, input logic eot,
                                            input logic last, input int len);
    logic [31:0] hdr;
    hdr                = '0;
    hdr[31:28]         = seg_type;
    hdr[`LWC_HDR_EOT]  = eot;
    hdr[`LWC_HDR_LAST] = last;
    hdr[15:0]          = len[15:0];
    return hdr;
endfunction

// Keep the leading nbytes bytes, clear the rest
function automatic logic [31:0] masked_word(input logic [31:0] word, input int nbytes);
    logic [31:0] keep;
    keep = '1;
    if (nbytes < 4) begin
        keep = ~(32'hffff_ffff >> (8 * nbytes));
    end
    return word & keep;
endfunction

task automatic queue_expected(input logic [31:0] word, input logic last);
    exp_q.push_back({last, word});
endtask

// Hold the word on PDI until the parser takes it
task automatic drive_word(input logic [31:0] word);
    int waited;
    waited = 0;
    @(negedge clk);
    pdi_data  = word;
    pdi_valid = 1'b1;
    while (!pdi_ready) begin
        if (waited >= timeout_cycles) begin
            $display("Timeout at %0t waiting for pdi_ready", $time);
            abort_run();
        end else begin
            waited++;
            @(negedge clk);
        end
    end
    @(posedge clk);
endtask

task automatic send_segment(input logic [3:0] seg_type, input logic eot, input logic last,
                            input int len, input logic forward);
    logic [31:0] hdr;
    logic [31:0] data;
    int          left;
    int          chunk;
    hdr = make_header(seg_type, eot, last, len);
    // Message headers leave as ciphertext headers
    if (forward) begin
        queue_expected({`LWC_SEG_CT, hdr[27:0]}, 1'b0);
    end
    drive_word(hdr);
    left = len;
    while (left > 0) begin
        chunk = (left < 4) ? left : 4;
        data  = $random(seed);
        if (forward) begin
            queue_expected(masked_word(data, chunk), 1'b0);
        end
        drive_word(data);
        left -= chunk;
    end
endtask

task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk);
    pdi_valid = 1'b0;
    pdi_data  = '0;
    while (exp_q.size() != 0) begin
        if (waited >= timeout_cycles) begin
            $display("Timeout with %0d DO words still expected", exp_q.size());
            abort_run();
        end else begin
            waited++;
            @(negedge clk);
        end
    end
    // Nothing extra left behind in the FIFO
    check_value("do_valid", {31'b0, do_valid}, 32'd0);
endtask

task automatic enc_single_message();
    drive_word({`LWC_OP_ENC, 28'h0});
    send_segment(`LWC_SEG_NPUB, 1'b1, 1'b0, 16, 1'b0);
    send_segment(`LWC_SEG_AD, 1'b1, 1'b0, 5, 1'b0);
    send_segment(`LWC_SEG_MSG, 1'b1, 1'b1, 10, 1'b1);
    queue_expected(`LWC_STATUS_OK, 1'b1);
    wait_drained();
endtask

task automatic enc_split_message();
    drive_word({`LWC_OP_ENC, 28'h0});
    send_segment(`LWC_SEG_NPUB, 1'b1, 1'b0, 12, 1'b0);
    // Empty AD segment
    send_segment(`LWC_SEG_AD, 1'b1, 1'b0, 0, 1'b0);
    send_segment(`LWC_SEG_MSG, 1'b0, 1'b0, 8, 1'b1);
    send_segment(`LWC_SEG_MSG, 1'b1, 1'b1, 3, 1'b1);
    queue_expected(`LWC_STATUS_OK, 1'b1);
    wait_drained();
endtask

task automatic enc_empty_message();
    drive_word({`LWC_OP_ENC, 28'h0});
    send_segment(`LWC_SEG_NPUB, 1'b1, 1'b0, 16, 1'b0);
    send_segment(`LWC_SEG_AD, 1'b1, 1'b0, 7, 1'b0);
    send_segment(`LWC_SEG_MSG, 1'b1, 1'b1, 0, 1'b1);
    queue_expected(`LWC_STATUS_OK, 1'b1);
    wait_drained();
endtask

task automatic hash_two_segments();
    drive_word({`LWC_OP_HASH, 28'h0});
    send_segment(hash_seg_type, 1'b0, 1'b0, 7, 1'b0);
    send_segment(hash_seg_type, 1'b1, 1'b1, 12, 1'b0);
    queue_expected(`LWC_STATUS_OK, 1'b1);
    wait_drained();
endtask

task automatic unknown_then_hash();
    drive_word({bad_opcode, 28'h0abc_def});
    wait_drained();
    hash_two_segments();
endtask

task automatic enc_with_backpressure();
    random_stall = 1'b1;
    enc_single_message();
    random_stall = 1'b0;
endtask

`endif

//--- tb_lwc_io.sv
// LWC I/O controller testbench
`timescale 1ns/1ps
`include "lwc_cfg.svh"

module tb_lwc_io;

    localparam int clk_period     = 20;
    localparam int timeout_cycles = 2000;
    localparam int seed_init      = 73153;

    // Type code for hash data segments and an opcode the parser does not know
    localparam logic [3:0] hash_seg_type = 4'b0111;
    localparam logic [3:0] bad_opcode    = 4'b0111;

    logic              clk;
    logic              rst;
    logic [`LWC_W-1:0] pdi_data;
    logic              pdi_valid;
    logic              pdi_ready;
    logic [`LWC_W-1:0] do_data;
    logic              do_valid;
    logic              do_last;
    logic              do_ready;

    // Expected DO words, do_last in the top bit
    logic [`LWC_W:0] exp_q [$];

    int   seed;
    logic random_stall;

    lwc_io_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_last   (do_last),
        .do_ready  (do_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    `include "tb_lwc_tasks.svh"

    // DO sink ready, optionally throttled
    always @(negedge clk) begin
        if (random_stall) begin
            do_ready = ($random(seed) & 1) != 0;
        end else begin
            do_ready = 1'b1;
        end
    end

    // Output monitor, one expected word per DO transfer
    always @(posedge clk) begin
        logic [`LWC_W:0] exp_entry;
        if (rst && do_valid && do_ready) begin
            if (exp_q.size() == 0) begin
                $display("DO word %h at %0t arrived with nothing expected", do_data, $time);
                abort_run();
            end else begin
                exp_entry = exp_q.pop_front();
                check_value("do_data", do_data, exp_entry[`LWC_W-1:0]);
                check_value("do_last", {31'b0, do_last}, {31'b0, exp_entry[`LWC_W]});
            end
        end
    end

    initial begin
        seed         = seed_init;
        random_stall = 1'b0;
        rst          = 1'b0;
        pdi_data     = '0;
        pdi_valid    = 1'b0;
        do_ready     = 1'b1;

        repeat (4) @(negedge clk);
        check_reset_outputs();
        rst = 1'b1;

        enc_single_message();
        enc_split_message();
        enc_empty_message();
        hash_two_segments();
        unknown_then_hash();
        enc_with_backpressure();

        if (exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d expected DO words never arrived", exp_q.size());
            abort_run();
        end
    end

endmodule

//--- build.f
+incdir+.
lwc_pkg.sv
lwc_segment_parser.sv
lwc_entry_fifo.sv
lwc_do_formatter.sv
lwc_io_top.sv
tb_lwc_io.sv

//--- Bender.yml
package:
  name: lwc_io

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lwc_pkg.sv
      - lwc_segment_parser.sv
      - lwc_entry_fifo.sv
      - lwc_do_formatter.sv
      - lwc_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lwc_io.sv
